/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = video_out_tb
FILELIST  = vdac.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/palette_ram.sv */
// palette memory with CPU write port, registered read port and aligned blank flag
`timescale 1ns/10ps

module palette_ram
	import vdac_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// CPU write port
	input  logic       cram_we,
	input  cram_addr_t cram_addr,
	input  color_t     cram_data,
	// pixel read port
	input  cram_addr_t rd_addr,
	input  logic       rd_blank,
	output color_t     pix_color
);

	// colour entries, contents survive reset
	color_t mem [PAL_DEPTH];

	// read data register
	color_t rd_data;

	// blank flag, one cycle behind rd_blank
	logic blank_d;

	// CPU write, visible to reads from the next cycle on
	always_ff @(posedge clk)
	begin
		if (cram_we)
		begin
			mem[cram_addr] <= cram_data;
		end
	end

	// registered read
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

	// delay blank to line up with the read data
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			blank_d <= 1'b0;
		end
		else
		begin
			blank_d <= rd_blank;
		end
	end

	// blanked pixels leave as black
	assign pix_color = blank_d ? '0 : rd_data;

endmodule

/* design/pwm_dither.sv */
// phase counter, colour split, PWM pattern lookup and registered two-phase DAC codes
`timescale 1ns/10ps

module pwm_dither
	import vdac_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// VGA mode takes the phase upper bit from the line parity
	input  logic      vga_on,
	input  logic      vga_line,
	// colour from the palette, already blanked
	input  color_t    pix_color,
	// two sub-pixel codes per channel
	output dac_pair_t dac_red,
	output dac_pair_t dac_grn,
	output dac_pair_t dac_blu
);

	// free running phase counter
	logic [1:0] ph_cnt;

	// dither phase for this cycle
	phase_t phase;

	// channel parts
	coarse_t red_coarse;
	coarse_t grn_coarse;
	coarse_t blu_coarse;
	fine_t   red_fine;
	fine_t   grn_fine;
	fine_t   blu_fine;

	// next output codes
	dac_pair_t red_next;
	dac_pair_t grn_next;
	dac_pair_t blu_next;

	// code for one sub-pixel, coarse plus one where the pattern bit is set
	function automatic dac_t sub_code(
		input coarse_t coarse,
		input fine_t   fine,
		input phase_t  ph,
		input logic    odd
	);
		logic [2:0] bit_idx;
		logic [7:0] pattern;
		logic       bump;
		bit_idx = {ph, odd};
		pattern = PWM_PATTERN[fine];
		bump    = pattern[bit_idx];
		// coarse 3 saturates
		if (!bump || coarse == 2'd3)
		begin
			return coarse;
		end
		return coarse + 2'd1;
	endfunction

	// both sub-pixels of one channel, odd code in the upper half
	function automatic dac_pair_t chan_pair(
		input coarse_t coarse,
		input fine_t   fine,
		input phase_t  ph
	);
		dac_t even_code;
		dac_t odd_code;
		even_code = sub_code(coarse, fine, ph, 1'b0);
		odd_code  = sub_code(coarse, fine, ph, 1'b1);
		return {odd_code, even_code};
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ph_cnt <= '0;
		end
		else
		begin
			ph_cnt <= ph_cnt + 2'd1;
		end
	end

	// line parity in VGA, counter bit 1 in TV
	assign phase = {vga_on ? vga_line : ph_cnt[1], ph_cnt[0]};

	// split {coarse, fine} per channel
	assign red_coarse = pix_color[14:13];
	assign red_fine   = pix_color[12:10];
	assign grn_coarse = pix_color[9:8];
	assign grn_fine   = pix_color[7:5];
	assign blu_coarse = pix_color[4:3];
	assign blu_fine   = pix_color[2:0];

	// pattern lookup
	assign red_next = chan_pair(red_coarse, red_fine, phase);
	assign grn_next = chan_pair(grn_coarse, grn_fine, phase);
	assign blu_next = chan_pair(blu_coarse, blu_fine, phase);

	// output codes, the DDR cell downstream muxes the two halves
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dac_red <= '0;
			dac_grn <= '0;
			dac_blu <= '0;
		end
		else
		begin
			dac_red <= red_next;
			dac_grn <= grn_next;
			dac_blu <= blu_next;
		end
	end

endmodule

/* design/source_select.sv */
// TV/VGA source mux, TV pixel latch, hi-res nibble selection and blank selection
`timescale 1ns/10ps

module source_select
	import vdac_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// source select, high for VGA
	input  logic       vga_on,
	// TV pixel strobe
	input  logic       c3,
	// pixel indices from both timing paths
	input  plex_t      vplex_in,
	input  plex_t      vgaplex,
	// nibble select, bit 0 for VGA and bit 1 for TV
	input  logic [1:0] plex_sel,
	// mode and blank of each source
	input  logic       tv_hires,
	input  logic       vga_hires,
	input  logic       tv_blank,
	input  logic       vga_blank,
	// towards the palette
	output cram_addr_t pal_index,
	output logic       pix_blank
);

	// TV index captured on the pixel strobe
	plex_t vplex;

	// index byte of the active source
	plex_t plex;

	// active source controls
	logic nib_low;
	logic hires;

	// nibble picked out of the index byte
	logic [3:0] nibble;

	// TV latch, holds between strobes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vplex <= '0;
		end
		else if (c3)
		begin
			vplex <= vplex_in;
		end
	end

	// source mux
	always_comb
	begin
		if (vga_on)
		begin
			plex      = vgaplex;
			nib_low   = plex_sel[0];
			hires     = vga_hires;
			pix_blank = vga_blank;
		end
		else
		begin
			plex      = vplex;
			nib_low   = plex_sel[1];
			hires     = tv_hires;
			pix_blank = tv_blank;
		end
	end

	// low nibble when the select bit is set, else high nibble
	assign nibble = nib_low ? plex[3:0] : plex[7:4];

	// hi-res maps into the top 16 palette entries
	always_comb
	begin
		if (hires)
		begin
			pal_index = {4'b1111, nibble};
		end
		else
		begin
			pal_index = plex;
		end
	end

endmodule

/* design/vdac_pkg.sv */
// width typedefs, palette depth and PWM pattern table for the colour output stage

package vdac_pkg;

	// pixel index byte as delivered by a timing path
	typedef logic [7:0] plex_t;

	// palette address
	typedef logic [7:0] cram_addr_t;

	// palette colour, red/green/blue with 5 bits each
	// each channel is {coarse[1:0], fine[2:0]}
	typedef logic [14:0] color_t;

	// coarse part of one channel, also the base DAC code
	typedef logic [1:0] coarse_t;

	// fine part of one channel, used as PWM level
	typedef logic [2:0] fine_t;

	// single DAC code
	typedef logic [1:0] dac_t;

	// two sub-pixel codes of one channel
	// upper half is the odd sub-pixel, lower half the even one
	typedef logic [3:0] dac_pair_t;

	// PWM phase, {line/frame parity, counter bit 0}
	typedef logic [1:0] phase_t;

	// number of palette entries
	localparam int PAL_DEPTH = 256;

	// PWM patterns indexed by fine level
	// bit k is used at phase k/2, sub-pixel k mod 2
	localparam logic [7:0] PWM_PATTERN [0:7] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

/* design/video_out.sv */
// colour output stage top: source selection, palette lookup and PWM dither
`timescale 1ns/10ps

module video_out
	import vdac_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// timing path inputs
	input  logic       vga_on,
	input  logic       c3,
	input  plex_t      vplex_in,
	input  plex_t      vgaplex,
	input  logic [1:0] plex_sel,
	input  logic       tv_hires,
	input  logic       vga_hires,
	input  logic       tv_blank,
	input  logic       vga_blank,
	input  logic       vga_line,
	// CPU palette writes
	input  logic       cram_we,
	input  cram_addr_t cram_addr,
	input  color_t     cram_data,
	// DAC codes, two sub-pixels per channel
	output dac_pair_t  dac_red,
	output dac_pair_t  dac_grn,
	output dac_pair_t  dac_blu
);

	cram_addr_t pal_index;
	logic       pix_blank;
	color_t     pix_color;

	source_select u_source_select (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.c3        (c3),
		.vplex_in  (vplex_in),
		.vgaplex   (vgaplex),
		.plex_sel  (plex_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.pal_index (pal_index),
		.pix_blank (pix_blank)
	);

	palette_ram u_palette_ram (
		.clk       (clk),
		.rst       (rst),
		.cram_we   (cram_we),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.rd_addr   (pal_index),
		.rd_blank  (pix_blank),
		.pix_color (pix_color)
	);

	pwm_dither u_pwm_dither (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.vga_line  (vga_line),
		.pix_color (pix_color),
		.dac_red   (dac_red),
		.dac_grn   (dac_grn),
		.dac_blu   (dac_blu)
	);

endmodule

/* tests/video_out_properties.sv */
// concurrent assertions on the palette read stage and the dither outputs, with their binds
`timescale 1ns/10ps

module video_out_properties
	import vdac_pkg::*;
(
	input logic      clk,
	input logic      rst,
	// palette side
	input logic      blank,
	input color_t    pal_color,
	// dither side
	input color_t    dith_color,
	input dac_pair_t dac_red,
	input dac_pair_t dac_grn,
	input dac_pair_t dac_blu
);

	// outputs clear on reset
	assert property (@(posedge clk)
		$past(rst) |-> (dac_red == 4'd0 && dac_grn == 4'd0 && dac_blu == 4'd0))
		else $error("DAC codes not zero after reset");

	// blank request on the read port gives black one cycle later
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(blank)) |-> pal_color == 15'd0)
		else $error("blanked read gave a non-zero colour");

	// fine level 0 gives the same code on both sub-pixels
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[12:10]) == 3'd0) |-> dac_red[3:2] == dac_red[1:0])
		else $error("red sub-pixels differ at fine level 0");
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[7:5]) == 3'd0) |-> dac_grn[3:2] == dac_grn[1:0])
		else $error("green sub-pixels differ at fine level 0");
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[2:0]) == 3'd0) |-> dac_blu[3:2] == dac_blu[1:0])
		else $error("blue sub-pixels differ at fine level 0");

	// coarse 3 stays at the top code
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[14:13]) == 2'd3) |-> dac_red == 4'hf)
		else $error("red code left the top level");
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[9:8]) == 2'd3) |-> dac_grn == 4'hf)
		else $error("green code left the top level");
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(dith_color[4:3]) == 2'd3) |-> dac_blu == 4'hf)
		else $error("blue code left the top level");

endmodule

// palette side, dither ports tied off
bind palette_ram video_out_properties u_palette_props (
	.clk        (clk),
	.rst        (rst),
	.blank      (rd_blank),
	.pal_color  (pix_color),
	.dith_color (15'd0),
	.dac_red    (4'd0),
	.dac_grn    (4'd0),
	.dac_blu    (4'd0)
);

// dither side, palette ports tied off
bind pwm_dither video_out_properties u_dither_props (
	.clk        (clk),
	.rst        (rst),
	.blank      (1'b0),
	.pal_color  (15'd0),
	.dith_color (pix_color),
	.dac_red    (dac_red),
	.dac_grn    (dac_grn),
	.dac_blu    (dac_blu)
);

/* tests/video_out_tb.sv */
// testbench for the colour output stage: clock, reset, stimulus, palette model and checks
`timescale 1ns/10ps

module video_out_tb
	import vdac_pkg::*;
();

	logic       clk = 1'b0;
	logic       rst;
	logic       vga_on;
	logic       c3;
	plex_t      vplex_in;
	plex_t      vgaplex;
	logic [1:0] plex_sel;
	logic       tv_hires;
	logic       vga_hires;
	logic       tv_blank;
	logic       vga_blank;
	logic       vga_line;
	logic       cram_we;
	cram_addr_t cram_addr;
	color_t     cram_data;
	dac_pair_t  dac_red;
	dac_pair_t  dac_grn;
	dac_pair_t  dac_blu;

	// reference state
	color_t      pal_model [PAL_DEPTH];
	plex_t       tv_latch = '0;
	logic [1:0]  cnt_model = 2'd0;
	color_t      rd_q [$];
	logic [11:0] exp_q [$];
	int          checks = 0;

	video_out uut (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.c3        (c3),
		.vplex_in  (vplex_in),
		.vgaplex   (vgaplex),
		.plex_sel  (plex_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.vga_line  (vga_line),
		.cram_we   (cram_we),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.dac_red   (dac_red),
		.dac_grn   (dac_grn),
		.dac_blu   (dac_blu)
	);

	always #5 clk = ~clk;

	// expected {red, grn, blu} pairs for one colour at one phase
	function automatic logic [11:0] expected_dac(input color_t color, input logic [1:0] cnt,
		input logic vga_mode, input logic line);
		phase_t      ph;
		logic [4:0]  chan;
		logic [7:0]  pat;
		logic [1:0]  code;
		logic [11:0] result;
		ph = {(vga_mode ? line : cnt[1]), cnt[0]};
		result = '0;
		for (int c = 0; c < 3; c++)
		begin
			chan = color[14 - 5*c -: 5];
			pat = PWM_PATTERN[chan[2:0]];
			for (int s = 0; s < 2; s++)
			begin
				code = chan[4:3];
				if (pat[2*ph + s] && chan[4:3] != 2'd3)
				begin
					code = chan[4:3] + 2'd1;
				end
				result[8 - 4*c + 2*s +: 2] = code;
			end
		end
		return result;
	endfunction

	// distinct colour per address
	function automatic color_t fill_color(input cram_addr_t a);
		return {a, ~a[7:1]} ^ 15'h2c5a;
	endfunction

	task automatic check_dac_pair(input string chan, input dac_pair_t got, input dac_pair_t want);
		if (got !== want)
		begin
			$display("Mismatch at %0t: %s channel got %h, expected %h", $time, chan, got, want);
			$display("Done: errors found");
			$fatal(1, "DAC code check failed");
		end
	endtask

	// one clock step, strobes fall back to idle
	task automatic next_cycle;
		@(posedge clk);
		cram_we <= 1'b0;
		c3 <= 1'b0;
	endtask

	task automatic wait_checks(input int target);
		int guard;
		guard = 0;
		while (checks < target && guard < 50)
		begin
			@(posedge clk);
			guard++;
		end
		if (checks < target)
		begin
			$display("Timeout: the compare pipeline stopped producing results");
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	endtask

	// compare at the falling edge, then model the coming rising edge
	always @(negedge clk)
	begin
		plex_t       pix_byte;
		logic        hires;
		logic        use_low;
		logic        blank;
		cram_addr_t  idx;
		logic [11:0] want;
		color_t      on_bus;
		if (!rst)
		begin
			if (exp_q.size() > 0)
			begin
				want = exp_q.pop_front();
				check_dac_pair("red", dac_red, want[11:8]);
				check_dac_pair("green", dac_grn, want[7:4]);
				check_dac_pair("blue", dac_blu, want[3:0]);
				checks++;
			end
			// colour on the palette output meets the phase of the coming edge
			if (rd_q.size() > 0)
			begin
				on_bus = rd_q.pop_front();
				exp_q.push_back(expected_dac(on_bus, cnt_model, vga_on, vga_line));
			end
			if (vga_on)
			begin
				pix_byte = vgaplex;
				hires    = vga_hires;
				use_low  = plex_sel[0];
				blank    = vga_blank;
			end
			else
			begin
				pix_byte = tv_latch;
				hires    = tv_hires;
				use_low  = plex_sel[1];
				blank    = tv_blank;
			end
			idx = pix_byte;
			if (hires)
			begin
				idx = use_low ? {4'hf, pix_byte[3:0]} : {4'hf, pix_byte[7:4]};
			end
			rd_q.push_back(blank ? 15'd0 : pal_model[idx]);
			// read sees the old entry, write lands at the same edge
			if (cram_we)
			begin
				pal_model[cram_addr] = cram_data;
			end
			if (c3)
			begin
				tv_latch = vplex_in;
			end
			cnt_model = cnt_model + 2'd1;
		end
	end

	initial
	begin
		cram_addr_t addr_q [$];
		cram_addr_t a;
		int         target;
		void'($urandom(32'h1cc8_ac85));
		rst = 1'b1;
		vga_on = 1'b1;
		c3 = 1'b0;
		vplex_in = '0;
		vgaplex = '0;
		plex_sel = 2'b00;
		tv_hires = 1'b0;
		vga_hires = 1'b0;
		tv_blank = 1'b0;
		vga_blank = 1'b1;
		vga_line = 1'b0;
		cram_we = 1'b0;
		cram_addr = '0;
		cram_data = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// fill the whole palette while the screen is blanked
		for (int i = 0; i < PAL_DEPTH; i++)
		begin
			next_cycle();
			cram_we <= 1'b1;
			cram_addr <= cram_addr_t'(i);
			cram_data <= fill_color(cram_addr_t'(i));
		end
		next_cycle();
		vga_blank <= 1'b0;

		// random writes, then lo-res VGA reads of the same entries
		for (int i = 0; i < 64; i++)
		begin
			a = cram_addr_t'($urandom());
			addr_q.push_back(a);
			next_cycle();
			cram_we <= 1'b1;
			cram_addr <= a;
			cram_data <= color_t'($urandom());
		end
		foreach (addr_q[i])
		begin
			next_cycle();
			vgaplex <= addr_q[i];
			vga_line <= 1'($urandom());
		end

		// hi-res VGA picks a nibble out of the top 16 entries
		for (int i = 240; i < PAL_DEPTH; i++)
		begin
			next_cycle();
			cram_we <= 1'b1;
			cram_addr <= cram_addr_t'(i);
			cram_data <= fill_color(cram_addr_t'(i));
		end
		for (int i = 0; i < 100; i++)
		begin
			next_cycle();
			vga_hires <= 1'b1;
			vgaplex <= plex_t'($urandom());
			plex_sel <= 2'($urandom());
			vga_line <= 1'($urandom());
		end

		// TV path with a sparse pixel strobe
		for (int i = 0; i < 200; i++)
		begin
			next_cycle();
			vga_on <= 1'b0;
			c3 <= ($urandom() % 3) == 0;
			vplex_in <= plex_t'($urandom());
			tv_hires <= 1'($urandom());
			plex_sel <= 2'($urandom());
		end

		// blanking on either source
		for (int i = 0; i < 100; i++)
		begin
			next_cycle();
			vga_on <= 1'($urandom());
			c3 <= 1'($urandom());
			vplex_in <= plex_t'($urandom());
			vgaplex <= plex_t'($urandom());
			tv_blank <= 1'($urandom());
			vga_blank <= 1'($urandom());
			vga_line <= 1'($urandom());
		end

		// every coarse/fine pair across all four phases
		for (int c = 0; c < 4; c++)
		begin
			for (int f = 0; f < 8; f++)
			begin
				next_cycle();
				cram_we <= 1'b1;
				cram_addr <= cram_addr_t'(c*8 + f);
				cram_data <= {coarse_t'(c), fine_t'(f), coarse_t'(3 - c), fine_t'(f),
					coarse_t'(c), fine_t'(7 - f)};
			end
		end
		for (int n = 0; n < 128; n++)
		begin
			next_cycle();
			vga_on <= 1'b1;
			vga_hires <= 1'b0;
			vga_blank <= 1'b0;
			tv_blank <= 1'b0;
			vgaplex <= plex_t'(n / 4);
			vga_line <= (n % 4) >= 2;
		end

		// the last pixel leaves the pipeline three compares later
		target = checks + 3;
		wait_checks(target);
		$display("Done: no errors");
		$finish;
	end

endmodule

/* vdac.f */
design/vdac_pkg.sv
design/source_select.sv
design/palette_ram.sv
design/pwm_dither.sv
design/video_out.sv
tests/video_out_properties.sv
tests/video_out_tb.sv
